// File: src/mldsa_norm_pkg.sv
// ####################################################################
// ML-DSA-87 only. Bounds assume a 23-bit coefficient in [0, q)
// Mode code 3 is reserved and is handled like the ct0 check
// ####################################################################
package mldsa_norm_pkg;

    // Field modulus and the split point for centered values
    localparam logic [22:0] mldsa_q = 23'd8380417;
    localparam logic [22:0] half_q  = 23'd4190208;

    // Memory word layout, four 24-bit lanes with the coefficient in the low 23 bits
    localparam int reg_size        = 24;
    localparam int coeff_width     = reg_size - 1;
    localparam int coeffs_per_word = 4;
    localparam int data_width      = coeffs_per_word * reg_size;

    // One polynomial of 256 coefficients fills 64 words
    localparam int words_per_poly = 64;
    localparam int word_cnt_width = $clog2(words_per_poly);
    localparam int mem_addr_width = 10;
    localparam int mem_depth      = 2 ** mem_addr_width;

    // Check selection codes
    localparam logic [1:0] mode_z   = 2'd0;
    localparam logic [1:0] mode_r0  = 2'd1;
    localparam logic [1:0] mode_ct0 = 2'd2;

    // Vector lengths, L for z and K for r0 and ct0
    localparam int num_poly_l     = 7;
    localparam int num_poly_k     = 8;
    localparam int poly_cnt_width = $clog2(num_poly_k);

    // Bounds on the centered magnitude; a value at or above the bound fails
    // gamma1 minus beta
    localparam logic [22:0] bound_z   = 23'd524168;
    // gamma2 minus beta
    localparam logic [22:0] bound_r0  = 23'd261768;
    // gamma2
    localparam logic [22:0] bound_ct0 = 23'd261888;

    // Controller states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_read = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

endpackage

// File: src/norm_check_unit.sv
// ####################################################################
// Purely combinational. The coefficient must already be reduced mod q
// ####################################################################
module norm_check_unit
    import mldsa_norm_pkg::*;
(
    input  logic                   enable,
    input  logic [1:0]             mode,
    input  logic [coeff_width-1:0] coeff,
    output logic                   invalid
);

    logic [coeff_width-1:0] magnitude;
    logic [coeff_width-1:0] bound;

    // Values above (q-1)/2 stand for negative numbers, so fold them back
    // to get the absolute value of the centered representative
    always_comb begin
        if (coeff > half_q) begin
            magnitude = mldsa_q - coeff;
        end else begin
            magnitude = coeff;
        end
    end

    // Pick the bound for the active check
    // The reserved code falls through to the ct0 bound
    always_comb begin
        case (mode)
            mode_z: begin
                bound = bound_z;
            end
            mode_r0: begin
                bound = bound_r0;
            end
            default: begin
                bound = bound_ct0;
            end
        endcase
    end

    // Only flag while a valid read word is on the bus, otherwise
    // leftover memory data would poison the sticky flag
    assign invalid = enable & (magnitude >= bound);

endmodule

// File: src/norm_check_ctrl.sv
// ####################################################################
// Reads one word per cycle with no gaps; start is ignored unless idle
// Mode and base address must be held stable for the whole check
// ####################################################################
module norm_check_ctrl
    import mldsa_norm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      norm_check_enable,
    input  logic [1:0]                mode,
    input  logic                      shuffling_enable,
    input  logic [word_cnt_width-1:0] randomness,
    input  logic [mem_addr_width-1:0] mem_base_addr,
    output logic                      mem_rd_en,
    output logic [mem_addr_width-1:0] mem_rd_addr,
    output logic                      check_enable,
    output logic                      norm_check_done
);

    logic [1:0]                state;
    logic [poly_cnt_width-1:0] poly_cnt;
    logic [poly_cnt_width-1:0] last_poly;
    logic [word_cnt_width-1:0] word_cnt;
    logic [word_cnt_width-1:0] start_off;
    logic [word_cnt_width-1:0] word_off;
    logic [word_cnt_width-1:0] next_off;
    logic                      start_req;
    logic                      last_word;
    logic                      last_vec_word;

    // A start only counts when nothing is in flight
    assign start_req = (state == st_idle) && norm_check_enable;

    assign last_word     = (word_cnt == word_cnt_width'(words_per_poly - 1));
    assign last_vec_word = last_word && (poly_cnt == last_poly);

    // Offset for the next polynomial, drawn fresh when shuffling is on
    assign next_off = shuffling_enable ? randomness : '0;

    // State machine: idle, one read cycle per word, then a single done cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else if (zeroize) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_req) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (last_vec_word) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Word and polynomial counters plus the per-polynomial start offset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            poly_cnt  <= '0;
            last_poly <= '0;
            word_cnt  <= '0;
            start_off <= '0;
        end else if (zeroize) begin
            poly_cnt  <= '0;
            last_poly <= '0;
            word_cnt  <= '0;
            start_off <= '0;
        end else if (start_req) begin
            poly_cnt  <= '0;
            word_cnt  <= '0;
            start_off <= next_off;
            // z walks L polynomials, r0 and ct0 walk K
            if (mode == mode_z) begin
                last_poly <= poly_cnt_width'(num_poly_l - 1);
            end else begin
                last_poly <= poly_cnt_width'(num_poly_k - 1);
            end
        end else if (state == st_read) begin
            // The word counter wraps to zero on its own at the end of a polynomial
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
                poly_cnt  <= poly_cnt + 1'b1;
                start_off <= next_off;
            end
        end
    end

    // Offset arithmetic wraps inside the polynomial, so every word is hit once
    assign word_off = word_cnt + start_off;

    assign mem_rd_addr = mem_base_addr + mem_addr_width'({poly_cnt, word_off});

    assign mem_rd_en       = (state == st_read);
    assign check_enable    = (state == st_read);
    assign norm_check_done = (state == st_done);

endmodule

// File: src/norm_check_top.sv
// ####################################################################
// Expects read data exactly one cycle after each request
// invalid is only meaningful in the cycle where norm_check_done is high
// ####################################################################
module norm_check_top
    import mldsa_norm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      norm_check_enable,
    input  logic [1:0]                mode,
    input  logic                      shuffling_enable,
    input  logic [word_cnt_width-1:0] randomness,
    input  logic [mem_addr_width-1:0] mem_base_addr,
    input  logic [data_width-1:0]     mem_rd_data,
    output logic                      mem_rd_en,
    output logic [mem_addr_width-1:0] mem_rd_addr,
    output logic                      invalid,
    output logic                      norm_check_ready,
    output logic                      norm_check_done
);

    logic [coeffs_per_word-1:0] unit_invalid;
    logic                       check_enable;
    logic                       check_enable_reg;
    logic                       ctrl_done;

    // One check unit per lane; the top bit of each 24-bit lane is unused
    for (genvar i = 0; i < coeffs_per_word; i++) begin : g_unit
        norm_check_unit u_unit (
            .enable  (check_enable_reg),
            .mode    (mode),
            .coeff   (mem_rd_data[i*reg_size +: coeff_width]),
            .invalid (unit_invalid[i])
        );
    end

    norm_check_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .shuffling_enable  (shuffling_enable),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .check_enable      (check_enable),
        .norm_check_done   (ctrl_done)
    );

    // Line up the enable with the registered memory output
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable_reg <= 1'b0;
        end else if (zeroize) begin
            check_enable_reg <= 1'b0;
        end else begin
            check_enable_reg <= check_enable;
        end
    end

    // Sticky flag over the whole vector
    // It is cleared right after done so the next check starts clean
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || norm_check_done) begin
            invalid <= 1'b0;
        end else begin
            invalid <= invalid | (|unit_invalid);
        end
    end

    // The controller's done comes one cycle early, since the last word
    // is still being absorbed into the flag; ready follows done by one
    // more cycle to leave room for the flag to be captured upstream
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else if (zeroize) begin
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else begin
            norm_check_done  <= ctrl_done;
            norm_check_ready <= norm_check_done;
        end
    end

endmodule

// File: src/coeff_ram.sv
// ####################################################################
// Single port: the host must not write while a check is reading
// Array contents are undefined until written
// ####################################################################
module coeff_ram
    import mldsa_norm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      wr_en,
    input  logic [mem_addr_width-1:0] wr_addr,
    input  logic [data_width-1:0]     wr_data,
    input  logic                      rd_en,
    input  logic [mem_addr_width-1:0] rd_addr,
    output logic [data_width-1:0]     rd_data
);

    logic [data_width-1:0] mem [mem_depth];

    // Storage array, written on the host port only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data appears on the cycle after the request and then holds
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/norm_check_subsys.sv
// ####################################################################
// Load the vector through the host port before pulsing the start
// done arrives a fixed 64*polys+2 cycles after the start edge
// ####################################################################
module norm_check_subsys
    import mldsa_norm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      norm_check_enable,
    input  logic [1:0]                mode,
    input  logic                      shuffling_enable,
    input  logic [word_cnt_width-1:0] randomness,
    input  logic [mem_addr_width-1:0] mem_base_addr,
    input  logic                      host_wr_en,
    input  logic [mem_addr_width-1:0] host_wr_addr,
    input  logic [data_width-1:0]     host_wr_data,
    output logic                      invalid,
    output logic                      norm_check_done,
    output logic                      norm_check_ready
);

    // Read channel between the controller and the memory
    logic                      mem_rd_en;
    logic [mem_addr_width-1:0] mem_rd_addr;
    logic [data_width-1:0]     mem_rd_data;

    // Coefficient store, host writes in and the checker reads out
    coeff_ram u_ram (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (host_wr_en),
        .wr_addr (host_wr_addr),
        .wr_data (host_wr_data),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

    norm_check_top u_norm (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .shuffling_enable  (shuffling_enable),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_data       (mem_rd_data),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .invalid           (invalid),
        .norm_check_ready  (norm_check_ready),
        .norm_check_done   (norm_check_done)
    );

endmodule

// File: dv/tb_norm_check_subsys.sv
// ####################################################################
// Reads dv/norm_check_golden.txt, so the run starts in the project root
// Every load fills eight polynomials, whatever the mode
// ####################################################################
module tb_norm_check_subsys
    import mldsa_norm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_tests = 32;

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize;
    logic                      norm_check_enable;
    logic [1:0]                mode;
    logic                      shuffling_enable;
    logic [word_cnt_width-1:0] randomness;
    logic [mem_addr_width-1:0] mem_base_addr;
    logic                      host_wr_en;
    logic [mem_addr_width-1:0] host_wr_addr;
    logic [data_width-1:0]     host_wr_data;
    logic                      invalid;
    logic                      norm_check_done;
    logic                      norm_check_ready;

    // One row per test with mode, shuffle, base, poly, word, lane, value, expected flag and event
    int golden [max_tests][9];
    int num_tests;
    int cycle_count;
    int cycle_limit;

    norm_check_subsys DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Fresh offset every cycle; the controller samples it once per polynomial
    always @(posedge clk) begin
        randomness <= word_cnt_width'($urandom);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with tests still running", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%0h expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_cycles(string name, int actual, int expected);
        if (actual != expected) begin
            $display("ERR %s: got 0x%0h expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // Words in the vector; z walks L polynomials, all other codes walk K
    function automatic int vector_words(int m);
        if (m == int'(mode_z)) begin
            return num_poly_l * words_per_poly;
        end
        return num_poly_k * words_per_poly;
    endfunction

    // Centered magnitude stays below bound_r0, the tightest of the three bounds
    function automatic logic [coeff_width-1:0] random_coeff();
        logic [coeff_width-1:0] mag;
        mag = coeff_width'($urandom % bound_r0);
        if ($urandom % 2 == 1 && mag != 0) begin
            return mldsa_q - mag;
        end
        return mag;
    endfunction

    task automatic load_vector(int t);
        logic [data_width-1:0] word;
        int                    target;
        target = golden[t][3] * words_per_poly + golden[t][4];
        for (int w = 0; w < num_poly_k * words_per_poly; w++) begin
            for (int lane = 0; lane < coeffs_per_word; lane++) begin
                word[lane*reg_size +: reg_size] = {1'b0, random_coeff()};
            end
            // Poly f puts the target past the vector, so nothing is planted
            if (w == target) begin
                word[golden[t][5]*reg_size +: reg_size] = {1'b0, coeff_width'(golden[t][6])};
            end
            @(posedge clk);
            host_wr_en   <= 1'b1;
            host_wr_addr <= mem_addr_width'(golden[t][2] + w);
            host_wr_data <= word;
        end
        @(posedge clk);
        host_wr_en <= 1'b0;
    endtask

    task automatic apply_start();
        @(posedge clk);
        norm_check_enable <= 1'b1;
        @(posedge clk);
        norm_check_enable <= 1'b0;
    endtask

    task automatic watch_quiet(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("norm_check_done", norm_check_done, 1'b0);
        end
    endtask

    // Called right after the start edge, so the first negedge is cycle one
    task automatic check_run(int t);
        int m;
        int n;
        m = vector_words(golden[t][0]);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > m + 50) begin
                $display("No done pulse within %0d cycles of the start", n);
                abort_run();
            end
        end while (!norm_check_done);
        check_cycles("start_to_done", n, m + 2);
        check_flag("invalid", invalid, 1'(golden[t][7]));
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!norm_check_ready && n < 4);
        check_cycles("done_to_ready", n, 1);
        // Done is a single cycle, and the flag has already been cleared
        check_flag("norm_check_done", norm_check_done, 1'b0);
        check_flag("invalid", invalid, 1'b0);
        @(negedge clk);
        check_flag("norm_check_ready", norm_check_ready, 1'b0);
    endtask

    initial begin
        int    fd;
        int    rc;
        string line;
        int    f [9];
        void'($urandom(32'h9da0));
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        norm_check_enable = 1'b0;
        mode              = mode_z;
        shuffling_enable  = 1'b0;
        randomness        = '0;
        mem_base_addr     = '0;
        host_wr_en        = 1'b0;
        host_wr_addr      = '0;
        host_wr_data      = '0;
        cycle_count       = 0;
        cycle_limit       = 0;
        num_tests         = 0;
        fd = $fopen("dv/norm_check_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file dv/norm_check_golden.txt");
            abort_run();
        end
        // Comment lines do not parse as nine hex fields and drop out here
        while (!$feof(fd) && num_tests < max_tests) begin
            rc = $fgets(line, fd);
            if (rc > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                  f[3], f[4], f[5], f[6], f[7], f[8]) == 9) begin
                for (int i = 0; i < 9; i++) begin
                    golden[num_tests][i] = f[i];
                end
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("The golden file holds no test lines");
            abort_run();
        end
        // Load plus run per test, more for tests with a zeroize or second start
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit += 512 + 600 + ((golden[t][8] != 0) ? 600 : 0);
        end
        cycle_limit += 1000;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            mode             <= 2'(golden[t][0]);
            shuffling_enable <= 1'(golden[t][1]);
            mem_base_addr    <= mem_addr_width'(golden[t][2]);
            load_vector(t);
            apply_start();
            if (golden[t][8] == 1) begin
                // Kill the run part way; nothing may come out of it
                repeat (100) @(posedge clk);
                zeroize <= 1'b1;
                @(posedge clk);
                zeroize <= 1'b0;
                @(negedge clk);
                check_flag("invalid", invalid, 1'b0);
                watch_quiet(vector_words(golden[t][0]) + 10);
                apply_start();
            end
            if (golden[t][8] == 2) begin
                fork
                    begin
                        repeat (4) @(posedge clk);
                        norm_check_enable <= 1'b1;
                        @(posedge clk);
                        norm_check_enable <= 1'b0;
                    end
                join_none
            end
            check_run(t);
            if (golden[t][8] == 2) begin
                watch_quiet(vector_words(golden[t][0]) + 10);
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: dv/norm_check_golden.txt
# mode shuffle base poly word lane value expected event, all hex; poly f plants nothing
# event 1 zeroizes part way and restarts, event 2 issues a second start while busy
0 0 000 f 00 0 000000 0 0
1 0 200 5 30 0 03fe88 1 0
2 0 100 f 00 0 000000 0 0
0 0 080 3 11 2 77e079 1 0
0 0 000 2 0a 1 07ff87 0 0
1 0 380 0 01 3 7be179 1 0
1 0 200 5 30 0 03fe87 0 0
2 0 000 6 22 1 7be101 1 0
2 0 100 1 07 2 03feff 0 0
0 0 000 6 3f 3 07ff88 1 0
3 1 000 7 3f 3 03ff00 1 0
0 1 000 7 3f 3 07ff88 0 0
1 1 200 5 30 0 03fe88 1 0
1 1 200 0 0a 0 03fe88 1 1
0 1 240 f 00 0 000000 0 2

// File: norm_check_subsys.f
src/mldsa_norm_pkg.sv
src/norm_check_unit.sv
src/norm_check_ctrl.sv
src/norm_check_top.sv
src/coeff_ram.sv
src/norm_check_subsys.sv
dv/tb_norm_check_subsys.sv

// File: Bender.yml
package:
  name: norm_check_subsys

sources:
  - src/mldsa_norm_pkg.sv
  - src/norm_check_unit.sv
  - src/norm_check_ctrl.sv
  - src/norm_check_top.sv
  - src/coeff_ram.sv
  - src/norm_check_subsys.sv
  - target: test
    files:
      - dv/tb_norm_check_subsys.sv
